// File: logic/mini_core_rrv_pkg.sv
package mini_core_rrv_pkg;

    // RV32I major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        R_OP   = 7'b0110011,
        I_OP   = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } t_opcode;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } t_alu_op;

    typedef enum logic [2:0] {
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } t_immediate;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_DMEM,
        WB_PC4
    } t_sel_wr_back;

    localparam logic [31:0] NOP = 32'h0000_0013; // ADDI x0,x0,0

endpackage

// File: logic/mini_core_rrv_ctrl.sv
`timescale 1ns/1ps

module mini_core_rrv_ctrl (
    input  logic                              Clock,
    input  logic                              rstN,
    input  logic [31:0]                       InstructionQ101H,
    input  logic                              BranchCondMetQ101H,
    output logic [4:0]                        RegSrc1Q101H,
    output logic [4:0]                        RegSrc2Q101H,
    output mini_core_rrv_pkg::t_alu_op        AluOpQ101H,
    output logic [31:0]                       ImmediateQ101H,
    output logic                              ImmInstrQ101H,
    output logic                              SelAluPcQ101H,
    output logic                              LuiQ101H,
    output logic                              BranchQ101H,
    output logic                              JalrQ101H,
    output logic                              DMemWrEnQ101H,
    output logic                              DMemRdEnQ101H,
    output logic [3:0]                        DMemByteEnQ101H,
    output logic                              SignExtQ101H,
    output logic                              JumpTakenQ101H,
    output logic [4:0]                        RegDstQ102H,
    output logic                              RegWrEnQ102H,
    output mini_core_rrv_pkg::t_sel_wr_back   SelWrBackQ102H,
    output logic [3:0]                        ByteEnQ102H,
    output logic                              SignExtQ102H,
    output logic                              WbValidQ102H
);
    import mini_core_rrv_pkg::*;

    logic [31:0]  DecInstrQ101H;
    logic         SquashQ101H;
    t_opcode      OpcodeQ101H;
    logic [2:0]   Funct3Q101H;
    logic         AltQ101H;
    logic         JalQ101H;
    logic         MemQ101H;
    logic         RegWrEnQ101H;
    t_sel_wr_back SelWrBackQ101H;
    t_immediate   ImmTypeQ101H;

    // Slot behind a taken transfer becomes a bubble
    assign DecInstrQ101H = SquashQ101H ? NOP : InstructionQ101H;

    assign OpcodeQ101H  = t_opcode'(DecInstrQ101H[6:0]);
    assign Funct3Q101H  = DecInstrQ101H[14:12];
    assign AltQ101H     = DecInstrQ101H[30]; // SUB and SRA select
    assign RegSrc1Q101H = DecInstrQ101H[19:15];
    assign RegSrc2Q101H = DecInstrQ101H[24:20];

    assign JalQ101H      = (OpcodeQ101H == JAL);
    assign JalrQ101H     = (OpcodeQ101H == JALR);
    assign BranchQ101H   = (OpcodeQ101H == BRANCH);
    assign LuiQ101H      = (OpcodeQ101H == LUI);
    assign DMemWrEnQ101H = (OpcodeQ101H == STORE);
    assign DMemRdEnQ101H = (OpcodeQ101H == LOAD);
    assign MemQ101H      = DMemWrEnQ101H || DMemRdEnQ101H;
    assign ImmInstrQ101H = (OpcodeQ101H != R_OP);
    assign SelAluPcQ101H = JalQ101H || BranchQ101H || (OpcodeQ101H == AUIPC);
    assign SignExtQ101H  = DMemRdEnQ101H && !Funct3Q101H[2]; // LB and LH

    assign RegWrEnQ101H = (OpcodeQ101H == R_OP) || (OpcodeQ101H == I_OP) || DMemRdEnQ101H ||
                          JalQ101H || JalrQ101H || LuiQ101H || (OpcodeQ101H == AUIPC);
    assign SelWrBackQ101H = (JalQ101H || JalrQ101H) ? WB_PC4 :
                            DMemRdEnQ101H           ? WB_DMEM : WB_ALU;

    assign DMemByteEnQ101H = !MemQ101H                    ? 4'b0000 :
                             (Funct3Q101H[1:0] == 2'b00) ? 4'b0001 :
                             (Funct3Q101H[1:0] == 2'b01) ? 4'b0011 : 4'b1111;

    assign JumpTakenQ101H = (BranchQ101H && BranchCondMetQ101H) || JalQ101H || JalrQ101H;

    always_comb begin
        AluOpQ101H = ADD; // Address and target math
        if ((OpcodeQ101H == R_OP) || (OpcodeQ101H == I_OP)) begin
            case (Funct3Q101H)
                3'b000:  AluOpQ101H = ((OpcodeQ101H == R_OP) && AltQ101H) ? SUB : ADD;
                3'b001:  AluOpQ101H = SLL;
                3'b010:  AluOpQ101H = SLT;
                3'b011:  AluOpQ101H = SLTU;
                3'b100:  AluOpQ101H = XOR;
                3'b101:  AluOpQ101H = AltQ101H ? SRA : SRL;
                3'b110:  AluOpQ101H = OR;
                default: AluOpQ101H = AND;
            endcase
        end
    end

    always_comb begin
        case (OpcodeQ101H)
            STORE:      ImmTypeQ101H = S_TYPE;
            BRANCH:     ImmTypeQ101H = B_TYPE;
            LUI, AUIPC: ImmTypeQ101H = U_TYPE;
            JAL:        ImmTypeQ101H = J_TYPE;
            default:    ImmTypeQ101H = I_TYPE;
        endcase
    end

    always_comb begin
        case (ImmTypeQ101H)
            S_TYPE:  ImmediateQ101H = {{20{DecInstrQ101H[31]}}, DecInstrQ101H[31:25],
                                       DecInstrQ101H[11:7]};
            B_TYPE:  ImmediateQ101H = {{20{DecInstrQ101H[31]}}, DecInstrQ101H[7],
                                       DecInstrQ101H[30:25], DecInstrQ101H[11:8], 1'b0};
            U_TYPE:  ImmediateQ101H = {DecInstrQ101H[31:12], 12'b0};
            J_TYPE:  ImmediateQ101H = {{12{DecInstrQ101H[31]}}, DecInstrQ101H[19:12],
                                       DecInstrQ101H[20], DecInstrQ101H[30:21], 1'b0};
            default: ImmediateQ101H = {{20{DecInstrQ101H[31]}}, DecInstrQ101H[31:20]};
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            SquashQ101H  <= 1'b0;
            RegWrEnQ102H <= 1'b0;
        end else begin
            SquashQ101H  <= JumpTakenQ101H;
            RegWrEnQ102H <= RegWrEnQ101H;
        end
    end

    always_ff @(posedge Clock) begin
        RegDstQ102H    <= DecInstrQ101H[11:7];
        SelWrBackQ102H <= SelWrBackQ101H;
        ByteEnQ102H    <= DMemByteEnQ101H;
        SignExtQ102H   <= SignExtQ101H;
    end

    assign WbValidQ102H = RegWrEnQ102H && (RegDstQ102H != 5'd0);

endmodule

// File: logic/mini_core_rrv_if.sv
`timescale 1ns/1ps

module mini_core_rrv_if #(
    parameter int ImemWords = 256
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         ImemWrEn,
    input  logic [$clog2(ImemWords)-1:0] ImemWrAddr,
    input  logic [31:0]                  ImemWrData,
    input  logic                         JumpTakenQ101H,
    input  logic [31:0]                  AluTargetQ101H,
    output logic [31:0]                  PcQ101H,
    output logic [31:0]                  InstructionQ101H
);
    import mini_core_rrv_pkg::*;

    localparam int AddrW = $clog2(ImemWords);

    logic [31:0] Imem [ImemWords];
    logic [31:0] PcQ100H;
    logic [31:0] NextPcQ100H;
    logic [31:0] ReadWordQ101H;
    logic        FetchValidQ101H; // Low until the first fetch after reset

    assign NextPcQ100H = JumpTakenQ101H ? AluTargetQ101H : PcQ100H + 32'd4;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            PcQ100H         <= '0;
            FetchValidQ101H <= 1'b0;
        end else begin
            PcQ100H         <= NextPcQ100H;
            FetchValidQ101H <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (ImemWrEn) begin
            Imem[ImemWrAddr] <= ImemWrData; // Program load
        end
        ReadWordQ101H <= Imem[PcQ100H[AddrW+1:2]];
        PcQ101H       <= PcQ100H;
    end

    assign InstructionQ101H = FetchValidQ101H ? ReadWordQ101H : NOP;

endmodule

// File: logic/mini_core_rrv_rf.sv
`timescale 1ns/1ps

module mini_core_rrv_rf (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [4:0]  RegSrc1Q101H,
    input  logic [4:0]  RegSrc2Q101H,
    input  logic [4:0]  RegDstQ102H,
    input  logic        RegWrEnQ102H,
    input  logic [31:0] WbDataQ102H,
    output logic [31:0] RegData1Q101H,
    output logic [31:0] RegData2Q101H
);
    logic [31:0] Regs [1:31]; // x0 has no storage

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                Regs[i] <= '0;
            end
        end else if (RegWrEnQ102H && (RegDstQ102H != 5'd0)) begin
            Regs[RegDstQ102H] <= WbDataQ102H;
        end
    end

    assign RegData1Q101H = (RegSrc1Q101H == 5'd0) ? '0 : Regs[RegSrc1Q101H];
    assign RegData2Q101H = (RegSrc2Q101H == 5'd0) ? '0 : Regs[RegSrc2Q101H];

endmodule

// File: logic/mini_core_rrv_exe.sv
`timescale 1ns/1ps

module mini_core_rrv_exe (
    input  logic                       Clock,
    input  logic                       rstN,
    input  logic [31:0]                RegData1Q101H,
    input  logic [31:0]                RegData2Q101H,
    input  logic [31:0]                PcQ101H,
    input  mini_core_rrv_pkg::t_alu_op AluOpQ101H,
    input  logic [31:0]                ImmediateQ101H,
    input  logic                       ImmInstrQ101H,
    input  logic                       SelAluPcQ101H,
    input  logic                       LuiQ101H,
    input  logic [4:0]                 RegSrc1Q101H,
    input  logic [4:0]                 RegSrc2Q101H,
    input  logic [4:0]                 RegDstQ102H,
    input  logic                       RegWrEnQ102H,
    input  logic [31:0]                WbDataQ102H,
    input  logic                       BranchQ101H,
    input  logic                       JalrQ101H,
    input  logic [2:0]                 Funct3Q101H,
    output logic [31:0]                AluTargetQ101H,
    output logic                       BranchCondMetQ101H,
    output logic [31:0]                AluOutQ101H,
    output logic [31:0]                StoreDataQ101H,
    output logic [31:0]                AluOutQ102H,
    output logic [31:0]                Pc4Q102H
);
    import mini_core_rrv_pkg::*;

    logic        FwdValidQ102H;
    logic [31:0] Rs1Q101H;
    logic [31:0] Rs2Q101H;
    logic [31:0] OpAQ101H;
    logic [31:0] OpBQ101H;
    logic        CondQ101H;

    // Q102 result bypass also covers load data
    assign FwdValidQ102H = RegWrEnQ102H && (RegDstQ102H != 5'd0);
    assign Rs1Q101H = (FwdValidQ102H && (RegDstQ102H == RegSrc1Q101H)) ? WbDataQ102H
                                                                         : RegData1Q101H;
    assign Rs2Q101H = (FwdValidQ102H && (RegDstQ102H == RegSrc2Q101H)) ? WbDataQ102H
                                                                         : RegData2Q101H;

    assign OpAQ101H = LuiQ101H      ? '0       :
                      SelAluPcQ101H ? PcQ101H : Rs1Q101H;
    assign OpBQ101H = ImmInstrQ101H ? ImmediateQ101H : Rs2Q101H;

    always_comb begin
        case (AluOpQ101H)
            SUB:     AluOutQ101H = OpAQ101H - OpBQ101H;
            SLL:     AluOutQ101H = OpAQ101H << OpBQ101H[4:0];
            SLT:     AluOutQ101H = {31'b0, $signed(OpAQ101H) < $signed(OpBQ101H)};
            SLTU:    AluOutQ101H = {31'b0, OpAQ101H < OpBQ101H};
            XOR:     AluOutQ101H = OpAQ101H ^ OpBQ101H;
            SRL:     AluOutQ101H = OpAQ101H >> OpBQ101H[4:0];
            SRA:     AluOutQ101H = $signed(OpAQ101H) >>> OpBQ101H[4:0];
            OR:      AluOutQ101H = OpAQ101H | OpBQ101H;
            AND:     AluOutQ101H = OpAQ101H & OpBQ101H;
            default: AluOutQ101H = OpAQ101H + OpBQ101H;
        endcase
    end

    always_comb begin
        case (Funct3Q101H)
            3'b000:  CondQ101H = (Rs1Q101H == Rs2Q101H);                 // BEQ
            3'b001:  CondQ101H = (Rs1Q101H != Rs2Q101H);                 // BNE
            3'b100:  CondQ101H = ($signed(Rs1Q101H) < $signed(Rs2Q101H)); // BLT
            3'b101:  CondQ101H = ($signed(Rs1Q101H) >= $signed(Rs2Q101H));
            3'b110:  CondQ101H = (Rs1Q101H < Rs2Q101H);                   // BLTU
            3'b111:  CondQ101H = (Rs1Q101H >= Rs2Q101H);
            default: CondQ101H = 1'b0;
        endcase
    end

    assign BranchCondMetQ101H = BranchQ101H && CondQ101H;
    // Adder output doubles as the target with bit 0 cleared for JALR
    assign AluTargetQ101H = {AluOutQ101H[31:1], AluOutQ101H[0] & !JalrQ101H};
    assign StoreDataQ101H = Rs2Q101H;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            AluOutQ102H <= '0;
            Pc4Q102H    <= '0;
        end else begin
            AluOutQ102H <= AluOutQ101H;
            Pc4Q102H    <= PcQ101H + 32'd4; // Link value for JAL and JALR
        end
    end

endmodule

// File: logic/mini_core_rrv_dmem_wb.sv
`timescale 1ns/1ps

module mini_core_rrv_dmem_wb #(
    parameter int DmemWords = 256
) (
    input  logic                            Clock,
    input  logic [31:0]                     AluOutQ101H,
    input  logic [31:0]                     StoreDataQ101H,
    input  logic                            DMemWrEnQ101H,
    input  logic                            DMemRdEnQ101H,
    input  logic [3:0]                      DMemByteEnQ101H,
    input  logic [31:0]                     AluOutQ102H,
    input  logic [31:0]                     Pc4Q102H,
    input  mini_core_rrv_pkg::t_sel_wr_back SelWrBackQ102H,
    input  logic [3:0]                      ByteEnQ102H,
    input  logic                            SignExtQ102H,
    output logic [31:0]                     WbDataQ102H
);
    import mini_core_rrv_pkg::*;

    localparam int AddrW = $clog2(DmemWords);

    logic [3:0][7:0]  Dmem [DmemWords];
    logic [AddrW-1:0] WordAddrQ101H;
    logic [3:0]       LaneEnQ101H;
    logic [31:0]      LaneDataQ101H;
    logic [31:0]      RdWordQ102H;
    logic [31:0]      ShiftedQ102H;
    logic [31:0]      LoadDataQ102H;

    assign WordAddrQ101H = AluOutQ101H[AddrW+1:2];
    assign LaneEnQ101H   = DMemByteEnQ101H << AluOutQ101H[1:0];
    assign LaneDataQ101H = DMemByteEnQ101H[2] ? StoreDataQ101H             :
                           DMemByteEnQ101H[1] ? {2{StoreDataQ101H[15:0]}} :
                                                {4{StoreDataQ101H[7:0]}};

    always_ff @(posedge Clock) begin
        if (DMemWrEnQ101H) begin
            for (int b = 0; b < 4; b++) begin
                if (LaneEnQ101H[b]) begin
                    Dmem[WordAddrQ101H][b] <= LaneDataQ101H[8*b +: 8];
                end
            end
        end
        if (DMemRdEnQ101H) begin
            RdWordQ102H <= Dmem[WordAddrQ101H];
        end
    end

    // Move the addressed lane down to bit 0
    assign ShiftedQ102H = RdWordQ102H >> {AluOutQ102H[1:0], 3'b000};

    always_comb begin
        case (ByteEnQ102H)
            4'b0001: LoadDataQ102H = {{24{SignExtQ102H & ShiftedQ102H[7]}}, ShiftedQ102H[7:0]};
            4'b0011: LoadDataQ102H = {{16{SignExtQ102H & ShiftedQ102H[15]}},
                                      ShiftedQ102H[15:0]};
            default: LoadDataQ102H = ShiftedQ102H;
        endcase
    end

    always_comb begin
        case (SelWrBackQ102H)
            WB_DMEM: WbDataQ102H = LoadDataQ102H;
            WB_PC4:  WbDataQ102H = Pc4Q102H;
            default: WbDataQ102H = AluOutQ102H;
        endcase
    end

endmodule

// File: logic/mini_core_rrv.sv
`timescale 1ns/1ps

module mini_core_rrv #(
    parameter int ImemWords = 256,
    parameter int DmemWords = 256
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         ImemWrEn,
    input  logic [$clog2(ImemWords)-1:0] ImemWrAddr,
    input  logic [31:0]                  ImemWrData,
    output logic                         WbValid,
    output logic [4:0]                   WbRegDst,
    output logic [31:0]                  WbData
);
    import mini_core_rrv_pkg::*;

    logic [31:0]  PcQ101H;
    logic [31:0]  InstructionQ101H;
    logic [4:0]   RegSrc1Q101H;
    logic [4:0]   RegSrc2Q101H;
    t_alu_op      AluOpQ101H;
    logic [31:0]  ImmediateQ101H;
    logic         ImmInstrQ101H;
    logic         SelAluPcQ101H;
    logic         LuiQ101H;
    logic         BranchQ101H;
    logic         JalrQ101H;
    logic         DMemWrEnQ101H;
    logic         DMemRdEnQ101H;
    logic [3:0]   DMemByteEnQ101H;
    logic         JumpTakenQ101H;
    logic         BranchCondMetQ101H;
    logic [31:0]  AluTargetQ101H;
    logic [31:0]  AluOutQ101H;
    logic [31:0]  StoreDataQ101H;
    logic [31:0]  RegData1Q101H;
    logic [31:0]  RegData2Q101H;
    logic [4:0]   RegDstQ102H;
    logic         RegWrEnQ102H;
    t_sel_wr_back SelWrBackQ102H;
    logic [3:0]   ByteEnQ102H;
    logic         SignExtQ102H;
    logic         WbValidQ102H;
    logic [31:0]  AluOutQ102H;
    logic [31:0]  Pc4Q102H;
    logic [31:0]  WbDataQ102H;

    mini_core_rrv_if #(.ImemWords(ImemWords)) uIf (.*);

    mini_core_rrv_ctrl uCtrl (
        .SignExtQ101H (), // Consumed through its Q102 copy
        .*
    );

    mini_core_rrv_rf uRf (.*);

    mini_core_rrv_exe uExe (
        .Funct3Q101H (InstructionQ101H[14:12]), // Branch kind
        .*
    );

    mini_core_rrv_dmem_wb #(.DmemWords(DmemWords)) uDmemWb (.*);

    assign WbValid  = WbValidQ102H;
    assign WbRegDst = RegDstQ102H;
    assign WbData   = WbDataQ102H;

endmodule

// File: tb/mini_core_rrv_sva.sv
`timescale 1ns/1ps

module mini_core_rrv_sva (
    input logic Clock,
    input logic rstN,
    input logic DMemWrEnQ101H,
    input logic DMemRdEnQ101H,
    input logic WbValidQ102H,
    input logic JumpTakenQ101H
);
    // Core must stay quiet while held in reset
    quietInReset: assert property (@(posedge Clock)
        !rstN |-> !DMemWrEnQ101H && !DMemRdEnQ101H && !WbValidQ102H)
        else $error("DMem enable or writeback while in reset");

    // Squashed slot sends no data-memory access
    squashNoMem: assert property (@(posedge Clock) disable iff (!rstN)
        JumpTakenQ101H |=> !DMemWrEnQ101H && !DMemRdEnQ101H)
        else $error("DMem access from the slot after a taken transfer");

    // Squashed slot reaches Q102 two cycles after the transfer
    squashNoWb: assert property (@(posedge Clock) disable iff (!rstN)
        JumpTakenQ101H |-> ##2 !WbValidQ102H)
        else $error("Instruction after a taken transfer wrote back");
endmodule

bind mini_core_rrv_ctrl mini_core_rrv_sva sva_i (
    .Clock          (Clock),
    .rstN           (rstN),
    .DMemWrEnQ101H  (DMemWrEnQ101H),
    .DMemRdEnQ101H  (DMemRdEnQ101H),
    .WbValidQ102H   (WbValidQ102H),
    .JumpTakenQ101H (JumpTakenQ101H)
);

// File: tb/mini_core_rrv_checker.sv
`timescale 1ns/1ps

module mini_core_rrv_checker #(
    parameter int ProgWords = 256
) (
    input  logic        Clock,
    input  logic        rstN,
    input  logic        WbValid,
    input  logic [4:0]  WbRegDst,
    input  logic [31:0] WbData,
    input  logic [31:0] Program [ProgWords],
    output int          errCount,
    output logic        modelDone,
    output int          pendingCount
);
    import mini_core_rrv_pkg::*;

    logic [31:0] regs [32];
    logic [7:0]  mem [1024];
    logic [31:0] pc;
    logic [36:0] expQueue [$]; // {rd, data}

    initial begin
        errCount     = 0;
        modelDone    = 1'b0;
        pendingCount = 0;
    end

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic isReg, input logic [31:0] a,
                                             input logic [31:0] b);
        case (f3)
            3'd0:    return (isReg && alt) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Execute one instruction of the reference model
    task automatic stepModel();
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        logic        taken;
        instr  = Program[pc[9:2]];
        rd     = instr[11:7];
        f3     = instr[14:12];
        a      = regs[instr[19:15]];
        b      = regs[instr[24:20]];
        nextPc = pc + 32'd4;
        wr     = 1'b0;
        val    = '0;
        taken  = 1'b0;
        addr   = a + {{20{instr[31]}}, instr[31:20]};
        case (t_opcode'(instr[6:0]))
            R_OP: begin
                val = aluModel(f3, instr[30], 1'b1, a, b);
                wr  = 1'b1;
            end
            I_OP: begin
                val = aluModel(f3, instr[30], 1'b0, a, {{20{instr[31]}}, instr[31:20]});
                wr  = 1'b1;
            end
            LUI: begin
                val = {instr[31:12], 12'b0};
                wr  = 1'b1;
            end
            AUIPC: begin
                val = pc + {instr[31:12], 12'b0};
                wr  = 1'b1;
            end
            LOAD: begin
                case (f3)
                    3'd0: val = {{24{mem[addr[9:0]][7]}}, mem[addr[9:0]]};
                    3'd1: val = {{16{mem[addr[9:0] + 10'd1][7]}}, mem[addr[9:0] + 10'd1],
                                 mem[addr[9:0]]};
                    3'd4: val = {24'b0, mem[addr[9:0]]};
                    3'd5: val = {16'b0, mem[addr[9:0] + 10'd1], mem[addr[9:0]]};
                    default: val = {mem[addr[9:0] + 10'd3], mem[addr[9:0] + 10'd2],
                                    mem[addr[9:0] + 10'd1], mem[addr[9:0]]};
                endcase
                wr = 1'b1;
            end
            STORE: begin
                addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                mem[addr[9:0]] = b[7:0];
                if (f3 != 3'd0) begin
                    mem[addr[9:0] + 10'd1] = b[15:8];
                end
                if (f3 == 3'd2) begin
                    mem[addr[9:0] + 10'd2] = b[23:16];
                    mem[addr[9:0] + 10'd3] = b[31:24];
                end
            end
            BRANCH: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) begin
                    nextPc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
            JAL: begin
                val    = pc + 32'd4;
                wr     = 1'b1;
                nextPc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                if (nextPc == pc) begin
                    modelDone = 1'b1; // Self-loop ends the program
                end
            end
            JALR: begin
                val    = pc + 32'd4;
                wr     = 1'b1;
                nextPc = {addr[31:1], 1'b0};
            end
            default: ;
        endcase
        if (wr && (rd != 5'd0)) begin
            regs[rd] = val;
            expQueue.push_back({rd, val});
        end
        pc = nextPc;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge Clock) begin
        logic [36:0] exp;
        int          guard;
        if (!rstN) begin
            pc        = '0;
            modelDone = 1'b0;
            expQueue.delete();
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < 1024; i++) begin
                mem[i] = '0;
            end
        end else begin
            guard = 0;
            while ((expQueue.size() == 0) && !modelDone && (guard < 1000)) begin
                stepModel();
                guard++;
            end
            if (WbValid) begin
                if (expQueue.size() == 0) begin
                    errCount++;
                    $display("[ERROR] %0t: unexpected writeback x%0d = %h",
                             $time, WbRegDst, WbData);
                end else begin
                    exp = expQueue.pop_front();
                    if ((exp[36:32] !== WbRegDst) || (exp[31:0] !== WbData)) begin
                        errCount++;
                        $display("[ERROR] %0t: writeback expected x%0d = %h, got x%0d = %h",
                                 $time, exp[36:32], exp[31:0], WbRegDst, WbData);
                    end
                end
            end
        end
        pendingCount = expQueue.size();
    end
endmodule

// File: tb/mini_core_rrv_tb.sv
`timescale 1ns/1ps

module mini_core_rrv_tb;
    import mini_core_rrv_pkg::*;

    localparam int ImemWords = 256;
    localparam int ProgLen   = 210; // Prologue, 200 random, self-loop

    logic        Clock;
    logic        rstN;
    logic        ImemWrEn;
    logic [7:0]  ImemWrAddr;
    logic [31:0] ImemWrData;
    logic        WbValid;
    logic [4:0]  WbRegDst;
    logic [31:0] WbData;
    logic [31:0] programWords [ImemWords];
    int          errCount;
    int          pendingCount;
    logic        modelDone;
    int          timeouts;
    int          cycles;

    mini_core_rrv #(.ImemWords(ImemWords), .DmemWords(256)) dut_i (.*);

    mini_core_rrv_checker #(.ProgWords(ImemWords)) checker_i (
        .Clock(Clock), .rstN(rstN), .WbValid(WbValid), .WbRegDst(WbRegDst),
        .WbData(WbData), .Program(programWords), .errCount(errCount),
        .modelDone(modelDone), .pendingCount(pendingCount)
    );

    always #5 Clock = ~Clock;

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] branchWord(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jalWord(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // One random instruction with forward targets inside the program
    function automatic logic [31:0] randomInstr(input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          steps;
        int          kind;
        rd    = 5'($urandom % 8);
        rs1   = 5'($urandom % 8);
        rs2   = 5'($urandom % 8);
        f3    = 3'($urandom % 8);
        imm   = 12'($urandom);
        kind  = int'($urandom % 10);
        steps = 1 + int'($urandom % 6);
        if (steps > ProgLen - 1 - idx) begin
            steps = ProgLen - 1 - idx;
        end
        case (kind)
            0, 1, 2: return {((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd, 7'b0110011};
            3, 4: begin
                if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                if (f3 == 3'd5) imm = {($urandom % 2 == 1) ? 7'h20 : 7'h00, imm[4:0]};
                return iTypeWord(imm, rs1, f3, rd, 7'b0010011);
            end
            5: return {imm, 8'($urandom), rd, ($urandom % 2 == 1) ? 7'b0110111 : 7'b0010111};
            6: begin
                f3 = ($urandom % 2 == 1) ? 3'd2 : 3'($urandom % 2 + 4 * ($urandom % 2));
                imm = (f3 == 3'd2) ? 12'(4 * ($urandom % 8)) :
                      (f3[0])      ? 12'(2 * ($urandom % 16)) : 12'($urandom % 32);
                return iTypeWord(imm, 5'd0, f3, rd, 7'b0000011);
            end
            7: begin
                f3 = 3'($urandom % 3);
                imm = (f3 == 3'd2) ? 12'(4 * ($urandom % 8)) :
                      (f3 == 3'd1) ? 12'(2 * ($urandom % 16)) : 12'($urandom % 32);
                return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
            end
            8: begin
                if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
                return branchWord(13'(steps * 4), rs2, rs1, f3);
            end
            default: begin
                if ($urandom % 2 == 1) return jalWord(21'(steps * 4), rd);
                return iTypeWord(12'((idx + steps) * 4), 5'd0, 3'd0, rd, 7'b1100111);
            end
        endcase
    endfunction

    initial begin
        void'($urandom(7));
        Clock      = 1'b0;
        rstN       = 1'b0;
        ImemWrEn   = 1'b0;
        ImemWrAddr = '0;
        ImemWrData = '0;
        timeouts   = 0;
        for (int i = 0; i < ImemWords; i++) begin
            programWords[i] = NOP;
        end
        programWords[0] = iTypeWord(12'h5a5, 5'd0, 3'd0, 5'd1, 7'b0010011);
        for (int i = 0; i < 8; i++) begin
            programWords[1 + i] = {7'd0, 5'd0, 5'd0, 3'd2, 5'(4 * i), 7'b0100011}; // Clear dmem
        end
        for (int i = 9; i < ProgLen - 1; i++) begin
            programWords[i] = randomInstr(i);
        end
        programWords[ProgLen - 1] = jalWord(21'd0, 5'd0);

        for (int i = 0; i < ImemWords; i++) begin // Load while in reset
            @(negedge Clock);
            ImemWrEn   = 1'b1;
            ImemWrAddr = 8'(i);
            ImemWrData = programWords[i];
        end
        @(negedge Clock);
        ImemWrEn = 1'b0;
        repeat (4) @(negedge Clock);
        rstN = 1'b1;

        cycles = 0;
        while (!(modelDone && pendingCount == 0) && cycles < 5000) begin
            @(negedge Clock);
            cycles++;
        end
        if (cycles >= 5000) begin
            timeouts++;
            $display("Run timed out before reaching the self-loop, %0d writebacks still expected",
                     pendingCount);
        end
        repeat (5) @(negedge Clock);
        $display("Run finished with %0d check errors and %0d timeouts", errCount, timeouts);
        if (errCount == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

// File: list.f
logic/mini_core_rrv_pkg.sv
logic/mini_core_rrv_ctrl.sv
logic/mini_core_rrv_if.sv
logic/mini_core_rrv_rf.sv
logic/mini_core_rrv_exe.sv
logic/mini_core_rrv_dmem_wb.sv
logic/mini_core_rrv.sv
tb/mini_core_rrv_sva.sv
tb/mini_core_rrv_checker.sv
tb/mini_core_rrv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module mini_core_rrv_tb -o sim_mini_core_rrv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_mini_core_rrv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation log holds no result line"
    exit 1
fi
exit 0
